// File: files.f
+incdir+include
verilog/min_pkg.sv
verilog/min_parse.sv
verilog/min_wdq.sv
verilog/min_rq.sv
verilog/min_l2_arb.sv
verilog/min_csr.sv
verilog/min_top.sv
dv/tb_clk_gen.sv
dv/tb_min_checker.sv
dv/tb_min.sv

// File: Makefile
# Verilator build and run of the inbound memory path testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_min
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_min.sv
// Testbench top for the JBus memory inbound path.
// Drives bus beats, APB accesses and l2_req_rdy on the rising edge. A
// reference model predicts each request (bank or drop) and the expected L2
// traffic and APB read data go to the checker. Five tests, one result line
// each, then a summary line and the overall verdict.
`timescale 1ns/1ps
`include "min_defs.svh"

module tb_min;
  import min_pkg::*;

  localparam int TMO = 2000;            // Cycle limit of every wait

  typedef struct packed {
    min_req_t   req;
    logic [3:0] hdr_flip;               // Parity bits inverted on header
    logic [3:0] dat_flip;               // Same on write data beat
  } txn_t;

  typedef struct packed {
    logic       drop;
    logic       apar;
    logic       nonex;
    logic [1:0] bank;
  } verdict_t;

  logic                   clk;
  logic                   rst_n;
  min_adtype_e            j_adtype;
  logic [`MIN_DATA_W-1:0] j_ad;
  logic [`MIN_PAR_W-1:0]  j_adp;
  logic                   aok;
  min_apb_req_t           apb_req;
  min_apb_rsp_t           apb_rsp;
  logic                   l2_req_vld;
  min_l2_req_t            l2_req;
  logic                   l2_req_rdy;

  logic                   exp_push;     // Checker feed
  min_l2_req_t            exp_item;
  logic                   apb_chk;
  min_apb_rsp_t           apb_exp;
  int                     n_chk;
  int                     n_err;
  int                     pending;

  logic [31:0]            lfsr_q;
  logic [7:0]             cfg_mem_size; // Model of CONFIG
  logic [1:0]             exp_err;      // Model of ERR
  logic [31:0]            exp_log;      // Model of LOG
  int                     tb_errs;      // Timeouts and protocol misses
  int                     test_no;
  int                     err_mark;
  string                  test_name;
  logic                   fell;
  txn_t                   t;

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(10)) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  min_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .j_adtype   (j_adtype),
    .j_ad       (j_ad),
    .j_adp      (j_adp),
    .aok        (aok),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .l2_req_vld (l2_req_vld),
    .l2_req     (l2_req),
    .l2_req_rdy (l2_req_rdy)
  );

  tb_min_checker u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .l2_req_vld (l2_req_vld),
    .l2_req     (l2_req),
    .l2_req_rdy (l2_req_rdy),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .exp_push   (exp_push),
    .exp_item   (exp_item),
    .apb_chk    (apb_chk),
    .apb_exp    (apb_exp),
    .n_chk      (n_chk),
    .n_err      (n_err),
    .pending    (pending)
  );

  // ********************
  // Random source
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);  // Galois, taps 32 30 26 25
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[62:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  // ********************
  // Reference model
  function automatic logic [3:0] par16(input logic [63:0] w);
    logic [3:0] p;
    for (int i = 0; i < 4; i++) begin
      p[i] = ^w[i*16 +: 16];            // Even parity per slice
    end
    return p;
  endfunction

  // Parity first, then range, else bank from addr[7:6]
  function automatic verdict_t predict(input txn_t x, input logic [7:0] msize);
    verdict_t v;
    logic     par_ok;
    par_ok  = (x.hdr_flip == 4'h0) && (x.req.op == OP_RD || x.dat_flip == 4'h0);
    v.apar  = !par_ok;
    v.nonex = par_ok && (x.req.addr[39:32] >= msize);
    v.drop  = v.apar || v.nonex;
    v.bank  = x.req.addr[`MIN_BANK_LO +: 2];
    return v;
  endfunction

  // Random request below the given memory size, good parity
  function automatic txn_t rand_txn(input logic [7:0] hi_lim);
    txn_t        x;
    logic [63:0] r;
    r          = rand_bits(1);
    x.req.op   = r[0] ? OP_WR : OP_RD;
    x.req.addr = {8'(rand_bits(8)) % hi_lim, 32'(rand_bits(32))};
    x.req.data = (x.req.op == OP_WR) ? rand_bits(64) : 64'h0;
    x.hdr_flip = 4'h0;
    x.dat_flip = 4'h0;
    return x;
  endfunction

  // ********************
  // Bus and APB drivers
  task automatic send_txn(input txn_t x);
    verdict_t    v;
    logic [63:0] hw;
    hw = {24'h0, x.req.addr};
    v  = predict(x, cfg_mem_size);
    if (v.drop) begin
      if (exp_err == 2'b00) exp_log = x.req.addr[31:0];  // First error only
      exp_err |= {v.nonex, v.apar};
    end
    @(posedge clk);
    j_adtype <= (x.req.op == OP_WR) ? AD_WR_HDR : AD_RD_HDR;
    j_ad     <= hw;
    j_adp    <= par16(hw) ^ x.hdr_flip;
    if (x.req.op == OP_WR) begin
      @(posedge clk);
      j_adtype <= AD_WR_DATA;
      j_ad     <= x.req.data;
      j_adp    <= par16(x.req.data) ^ x.dat_flip;
    end
    exp_push <= !v.drop;                // With the last beat
    exp_item <= '{bank: v.bank, req: x.req};
    @(posedge clk);
    j_adtype <= AD_IDLE;                // Idle gap after every transaction
    j_ad     <= '0;
    j_adp    <= '0;
    exp_push <= 1'b0;
  endtask

  // Setup phase, access phase, then idle
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp_rd, input logic exp_slv);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    apb_chk <= 1'b1;
    apb_exp <= '{prdata: exp_rd, pready: 1'b1, pslverr: exp_slv};
    @(posedge clk);
    apb_req <= '0;
    apb_chk <= 1'b0;
  endtask

  // ********************
  // Waits, each bounded
  task automatic wait_aok(input string why);
    int n;
    n = 0;
    @(negedge clk);
    while (!aok && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (!aok) begin
      tb_errs++;
      $display("ERROR timeout: aok stayed low while waiting to %s", why);
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    @(negedge clk);                     // Checker has taken the last expectation
    while (pending != 0 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      tb_errs++;
      $display("ERROR timeout: %0d expected L2 requests never arrived", pending);
    end
    repeat (6) @(negedge clk);          // Room for a stray dropped request
  endtask

  task automatic start_test(input string name);
    test_no++;
    test_name = name;
    err_mark  = n_err + tb_errs;
  endtask

  task automatic finish_test();
    @(negedge clk);                     // Last checks of the test are counted
    $display("test %0d %s: %0d errors", test_no, test_name, n_err + tb_errs - err_mark);
  endtask

  // ********************
  // Test sequence
  initial begin
    int n;
    j_adtype     = AD_IDLE;
    j_ad         = '0;
    j_adp        = '0;
    apb_req      = '0;
    l2_req_rdy   = 1'b1;
    exp_push     = 1'b0;
    exp_item     = '0;
    apb_chk      = 1'b0;
    apb_exp      = '0;
    lfsr_q       = 32'h11f2_66c9;
    cfg_mem_size = `MIN_MEMSIZE_RST;
    exp_err      = 2'b00;
    exp_log      = 32'h0;
    tb_errs      = 0;
    test_no      = 0;

    n = 0;
    while (!rst_n && n < TMO) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) begin
      tb_errs++;
      $display("ERROR timeout: reset was never released");
    end
    repeat (2) @(posedge clk);

    // Register reset values and unmapped offset
    start_test("reset values");
    apb_xfer(1'b0, `MIN_REG_CONFIG, 32'h0, 32'(`MIN_MEMSIZE_RST), 1'b0);
    apb_xfer(1'b0, `MIN_REG_WMARK, 32'h0, {24'h0, `MIN_WMARK_LO_RST, `MIN_WMARK_HI_RST}, 1'b0);
    apb_xfer(1'b0, `MIN_REG_ERR, 32'h0, 32'h0, 1'b0);
    apb_xfer(1'b0, `MIN_REG_LOG, 32'h0, 32'h0, 1'b0);
    apb_xfer(1'b0, 8'h10, 32'h0, 32'h0, 1'b1);
    @(negedge clk);
    if (!aok) begin
      tb_errs++;
      $display("ERROR aok is low after reset");
    end
    finish_test();

    // Random good traffic, ready always high
    start_test("delivery");
    for (int i = 0; i < 40; i++) begin
      wait_aok("send a request");
      send_txn(rand_txn(cfg_mem_size));
    end
    wait_drained();
    finish_test();

    // Bad header parity on a read, bad data parity on a write
    start_test("parity error");
    t          = rand_txn(cfg_mem_size);
    t.req.op   = OP_RD;
    t.req.data = '0;
    t.hdr_flip = 4'b0001 << 2'(rand_bits(2));
    send_txn(t);
    t          = rand_txn(cfg_mem_size);
    t.req.op   = OP_WR;
    t.dat_flip = 4'b0001 << 2'(rand_bits(2));
    send_txn(t);
    send_txn(rand_txn(cfg_mem_size));   // Good one still delivered
    wait_drained();
    apb_xfer(1'b0, `MIN_REG_ERR, 32'h0, {30'h0, exp_err}, 1'b0);
    apb_xfer(1'b0, `MIN_REG_LOG, 32'h0, exp_log, 1'b0);
    apb_xfer(1'b1, `MIN_REG_ERR, 32'h1, 32'h0, 1'b0);
    exp_err &= 2'b10;                   // W1C on bit 0
    apb_xfer(1'b0, `MIN_REG_ERR, 32'h0, {30'h0, exp_err}, 1'b0);
    finish_test();

    // Smaller memory, boundary address and above
    start_test("nonexistent address");
    apb_xfer(1'b1, `MIN_REG_CONFIG, 32'h20, 32'h0, 1'b0);
    cfg_mem_size = 8'h20;
    apb_xfer(1'b0, `MIN_REG_CONFIG, 32'h0, 32'h20, 1'b0);
    t = rand_txn(8'h80);
    t.req.addr[39:32] = 8'h20;          // Exactly at the limit
    send_txn(t);
    t = rand_txn(8'h80);
    t.req.addr[39:32] = 8'h20 + (8'(rand_bits(8)) % 8'he0);
    send_txn(t);
    wait_drained();
    apb_xfer(1'b0, `MIN_REG_ERR, 32'h0, {30'h0, exp_err}, 1'b0);
    apb_xfer(1'b0, `MIN_REG_LOG, 32'h0, exp_log, 1'b0);
    apb_xfer(1'b1, `MIN_REG_ERR, 32'h3, 32'h0, 1'b0);
    exp_err = 2'b00;
    apb_xfer(1'b0, `MIN_REG_ERR, 32'h0, 32'h0, 1'b0);
    for (int i = 0; i < 12; i++) begin
      wait_aok("send a request");
      send_txn(rand_txn(cfg_mem_size));
    end
    wait_drained();
    apb_xfer(1'b1, `MIN_REG_CONFIG, 32'(`MIN_MEMSIZE_RST), 32'h0, 1'b0);
    cfg_mem_size = `MIN_MEMSIZE_RST;
    finish_test();

    // Ready held low, send only while aok is high
    start_test("back-pressure");
    @(posedge clk);
    l2_req_rdy <= 1'b0;
    fell = 1'b0;
    for (int i = 0; i < 64; i++) begin
      @(negedge clk);
      if (!aok) begin
        fell = 1'b1;
        break;
      end
      send_txn(rand_txn(cfg_mem_size));
    end
    if (!fell) begin
      tb_errs++;
      $display("ERROR aok never fell while l2_req_rdy was held low");
    end
    repeat (10) @(posedge clk);         // Late requests settle in the queues
    l2_req_rdy <= 1'b1;
    wait_drained();
    wait_aok("see aok rise after the queues drained");
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", test_no, n_chk, n_err + tb_errs);
    if (n_err + tb_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: dv/tb_min_checker.sv
// Scoreboard of the inbound memory path testbench.
// Keeps one queue of expected L2 requests per bank, fed by the testbench top,
// and matches every L2 transfer against the head of its bank's queue. Also
// checks APB responses that the top marks for checking. Counts checks and
// errors for the closing summary.
`timescale 1ns/1ps
`include "min_defs.svh"

module tb_min_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  l2_req_vld,
  input  min_pkg::min_l2_req_t  l2_req,
  input  logic                  l2_req_rdy,
  input  min_pkg::min_apb_req_t apb_req,
  input  min_pkg::min_apb_rsp_t apb_rsp,
  input  logic                  exp_push,   // One expected request this cycle
  input  min_pkg::min_l2_req_t  exp_item,
  input  logic                  apb_chk,    // Check this APB access phase
  input  min_pkg::min_apb_rsp_t apb_exp,
  output int                    n_chk,
  output int                    n_err,
  output int                    pending     // Expected but not yet seen
);
  import min_pkg::*;

  localparam int NB       = `MIN_NUM_BANKS;
  localparam int MAX_HELD = `MIN_RQ_DEPTH + 1;  // Queue plus arbiter output stage

  min_l2_req_t exp_q [NB][$];   // Expected traffic, one queue per bank
  min_l2_req_t want;
  logic [1:0]  b;

  // One value check, FAIL line on mismatch
  task automatic compare(input string name, input logic [63:0] got,
                         input logic [63:0] exp);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("FAIL %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  // ********************
  // Compare process
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      n_chk   = 0;
      n_err   = 0;
      pending = 0;
      for (int i = 0; i < NB; i++) begin
        exp_q[i].delete();
      end
    end else begin
      // New expectation from the stimulus side
      if (exp_push) begin
        exp_q[exp_item.bank].push_back(exp_item);
        pending++;
        if (exp_q[exp_item.bank].size() > MAX_HELD) begin
          n_err++;
          $display("ERROR bank %0d was given more requests than its queue can hold",
                   exp_item.bank);
        end
      end

      // L2 transfer, valid and ready both high
      if (l2_req_vld && l2_req_rdy) begin
        b = l2_req.bank;
        if (exp_q[b].size() == 0) begin
          n_err++;
          $display("ERROR unexpected L2 request on bank %0d, addr 0x%0h", b,
                   l2_req.req.addr);
        end else begin
          want = exp_q[b].pop_front();   // Wrong bank tag shows up as wrong addr
          pending--;
          compare("l2_req.req.op", 64'(l2_req.req.op), 64'(want.req.op));
          compare("l2_req.req.addr", 64'(l2_req.req.addr), 64'(want.req.addr));
          compare("l2_req.req.data", l2_req.req.data, want.req.data);
        end
      end

      // APB access phase marked by the top
      if (apb_chk && apb_req.psel && apb_req.penable) begin
        compare("apb_rsp.pready", 64'(apb_rsp.pready), 64'(apb_exp.pready));
        compare("apb_rsp.pslverr", 64'(apb_rsp.pslverr), 64'(apb_exp.pslverr));
        if (!apb_req.pwrite && !apb_exp.pslverr) begin
          compare("apb_rsp.prdata", 64'(apb_rsp.prdata), 64'(apb_exp.prdata));
        end
      end
    end
  end

endmodule

// File: dv/tb_clk_gen.sv
// Clock and reset source for the inbound memory path testbench.
// Free running clock, reset held low for a fixed number of rising edges and
// then released on an edge.
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;                   // Released on an edge like the stimulus
  end

endmodule

// File: verilog/min_top.sv
// Top of the JBus memory inbound path.
// Bus beats go through the parser and dispatcher into one queue per L2 bank,
// and the arbiter merges the queues onto a single L2 request port. The APB
// register block sets memory size and watermarks and logs errors.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  min_pkg::min_adtype_e   j_adtype,
  input  logic [`MIN_DATA_W-1:0] j_ad,
  input  logic [`MIN_PAR_W-1:0]  j_adp,
  output logic                   aok,
  input  min_pkg::min_apb_req_t  apb_req,
  output min_pkg::min_apb_rsp_t  apb_rsp,
  output logic                   l2_req_vld,
  output min_pkg::min_l2_req_t   l2_req,
  input  logic                   l2_req_rdy
);
  import min_pkg::*;

  localparam int NB = `MIN_NUM_BANKS;

  logic               parse_vld;
  min_req_t           parse_req;
  min_err_t           parse_err;
  logic [7:0]         mem_size;
  logic [3:0]         wmark_hi;
  logic [3:0]         wmark_lo;
  logic [NB-1:0]      push;
  min_req_t           entry;      // Common write data of all queues
  logic [NB-1:0][3:0] level;
  logic [NB-1:0]      nonempty;
  min_req_t [NB-1:0]  head;
  logic [NB-1:0]      pop;

  // ********************
  // Inbound
  min_parse u_parse (
    .clk       (clk),
    .rst_n     (rst_n),
    .j_adtype  (j_adtype),
    .j_ad      (j_ad),
    .j_adp     (j_adp),
    .mem_size  (mem_size),
    .parse_vld (parse_vld),
    .parse_req (parse_req),
    .parse_err (parse_err)
  );

  min_wdq u_wdq (
    .clk       (clk),
    .rst_n     (rst_n),
    .parse_vld (parse_vld),
    .parse_req (parse_req),
    .level     (level),
    .wmark_hi  (wmark_hi),
    .wmark_lo  (wmark_lo),
    .push      (push),
    .entry     (entry),
    .aok       (aok)
  );

  // ********************
  // Bank queues
  for (genvar i = 0; i < NB; i++) begin : g_rq
    min_rq #(.DEPTH(`MIN_RQ_DEPTH)) u_rq (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push[i]),
      .entry    (entry),
      .pop      (pop[i]),
      .nonempty (nonempty[i]),
      .head     (head[i]),
      .level    (level[i])
    );
  end

  min_l2_arb u_l2_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .nonempty   (nonempty),
    .head       (head),
    .pop        (pop),
    .l2_req_vld (l2_req_vld),
    .l2_req     (l2_req),
    .l2_req_rdy (l2_req_rdy)
  );

  min_csr u_csr (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .parse_err (parse_err),
    .mem_size  (mem_size),
    .wmark_hi  (wmark_hi),
    .wmark_lo  (wmark_lo)
  );

endmodule

// File: verilog/min_csr.sv
// APB register block of the inbound memory path.
// CONFIG and WMARK feed the parser and dispatcher. ERR collects sticky
// apar/nonex bits, cleared by writing 1. LOG keeps header address bits 31:0
// of the first error seen while ERR was clear. Zero wait states.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_csr (
  input  logic                 clk,
  input  logic                 rst_n,
  input  min_pkg::min_apb_req_t apb_req,
  output min_pkg::min_apb_rsp_t apb_rsp,
  input  min_pkg::min_err_t    parse_err,
  output logic [7:0]           mem_size,
  output logic [3:0]           wmark_hi,
  output logic [3:0]           wmark_lo
);
  logic                   acc;      // APB access phase
  logic                   wr_en;
  logic                   mapped;
  logic [1:0]             err_q;    // [1] nonex, [0] apar
  logic [1:0]             err_set;
  logic [1:0]             err_clr;
  logic [31:0]            log_q;
  logic [`MIN_APB_DW-1:0] rdata;

  assign acc     = apb_req.psel && apb_req.penable;
  assign wr_en   = acc && apb_req.pwrite;
  assign err_set = {parse_err.nonex, parse_err.apar};
  assign err_clr = (wr_en && apb_req.paddr == `MIN_REG_ERR) ? apb_req.pwdata[1:0] : 2'b00;

  // ********************
  // Read mux
  always_comb begin
    mapped = 1'b1;
    rdata  = '0;
    case (apb_req.paddr)
      `MIN_REG_CONFIG: rdata[7:0] = mem_size;
      `MIN_REG_WMARK:  rdata[7:0] = {wmark_lo, wmark_hi};
      `MIN_REG_ERR:    rdata[1:0] = err_q;
      `MIN_REG_LOG:    rdata      = log_q;
      default:         mapped     = 1'b0;   // Unmapped offset
    endcase
  end

  assign apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: acc && !mapped};

  // Config registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_size <= `MIN_MEMSIZE_RST;
      wmark_hi <= `MIN_WMARK_HI_RST;
      wmark_lo <= `MIN_WMARK_LO_RST;
    end else if (wr_en) begin
      if (apb_req.paddr == `MIN_REG_CONFIG) mem_size <= apb_req.pwdata[7:0];
      if (apb_req.paddr == `MIN_REG_WMARK) begin
        wmark_hi <= apb_req.pwdata[3:0];
        wmark_lo <= apb_req.pwdata[7:4];
      end
    end
  end

  // ********************
  // Error status, new errors win over clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= '0;
      log_q <= '0;
    end else begin
      if (err_q == 2'b00 && err_set != 2'b00) log_q <= parse_err.addr[31:0];
      err_q <= (err_q & ~err_clr) | err_set;
    end
  end

endmodule

// File: verilog/min_l2_arb.sv
// L2 request arbiter.
// Drains the bank queues round robin onto one valid/ready L2 port. A grant
// pops the queue and loads the output register, tagged with its bank, when
// that register is empty or transferring.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_l2_arb (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [`MIN_NUM_BANKS-1:0]            nonempty,
  input  min_pkg::min_req_t [`MIN_NUM_BANKS-1:0] head,
  output logic [`MIN_NUM_BANKS-1:0]            pop,
  output logic                                 l2_req_vld,
  output min_pkg::min_l2_req_t                 l2_req,
  input  logic                                 l2_req_rdy
);
  import min_pkg::*;

  localparam int NB = `MIN_NUM_BANKS;
  localparam int BW = $clog2(NB);

  logic [BW-1:0] last_q;    // Last granted bank
  logic [BW-1:0] gnt_idx;
  logic          gnt_vld;
  logic          load_ok;   // Output register free next cycle
  min_l2_req_t   nxt_req;

  assign load_ok = !l2_req_vld || l2_req_rdy;

  // Scan farthest first so the nearest bank after last_q wins
  always_comb begin
    logic [BW-1:0] idx;
    gnt_vld = 1'b0;
    gnt_idx = last_q;
    for (int k = NB; k >= 1; k--) begin
      idx = last_q + BW'(k);
      if (nonempty[idx]) begin
        gnt_vld = 1'b1;
        gnt_idx = idx;
      end
    end
  end

  always_comb begin
    pop = '0;
    if (load_ok && gnt_vld) pop[gnt_idx] = 1'b1;
  end

  assign nxt_req = '{bank: gnt_idx, req: head[gnt_idx]};

  // ********************
  // Output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      l2_req_vld <= 1'b0;
      last_q     <= BW'(NB-1);     // Bank 0 first
    end else if (load_ok) begin
      l2_req_vld <= gnt_vld;
      if (gnt_vld) last_q <= gnt_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ok && gnt_vld) l2_req <= nxt_req;
  end

  // Stalled request held until taken
  a_l2_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (l2_req_vld && !l2_req_rdy) |=> (l2_req_vld && $stable(l2_req)));

endmodule

// File: verilog/min_rq.sv
// Per-bank request queue.
// Circular FIFO of requests, DEPTH a power of two and at least 2. The head
// shows a pushed entry one clock later; level reports the fill for aok.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_rq #(
  parameter int DEPTH = `MIN_RQ_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  min_pkg::min_req_t entry,
  input  logic              pop,
  output logic              nonempty,
  output min_pkg::min_req_t head,
  output logic [3:0]        level
);
  import min_pkg::*;

  localparam int PW = $clog2(DEPTH);

  min_req_t      mem [DEPTH];   // Storage
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0]   count_q;       // 0..DEPTH
  logic          full;

  assign full     = (count_q == (PW+1)'(DEPTH));
  assign nonempty = (count_q != '0);
  assign head     = mem[rd_ptr_q];
  assign level    = 4'(count_q);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= entry;
    end
  end

  // ********************
  // Pointers and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;       // Both or neither
      endcase
    end
  end

  // Dispatcher flow control keeps pushes off a full queue
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  // Arbiter only pops banks it saw nonempty
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> nonempty);

endmodule

// File: verilog/min_wdq.sv
// Request dispatcher.
// Steers each parsed request to its bank queue by addr[7:6] and drives aok
// to the bus source, with hysteresis between the high and low watermarks.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_wdq (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            parse_vld,
  input  min_pkg::min_req_t               parse_req,
  input  logic [`MIN_NUM_BANKS-1:0][3:0]  level,
  input  logic [3:0]                      wmark_hi,
  input  logic [3:0]                      wmark_lo,
  output logic [`MIN_NUM_BANKS-1:0]       push,
  output min_pkg::min_req_t               entry,
  output logic                            aok
);
  localparam int NB = `MIN_NUM_BANKS;
  localparam int BW = $clog2(NB);

  logic [BW-1:0] bank;
  logic          any_hi;   // Some queue at or over high mark
  logic          all_lo;   // Every queue at or under low mark

  assign bank  = parse_req.addr[`MIN_BANK_LO +: BW];
  assign entry = parse_req;                    // Shared by all queues

  always_comb begin
    any_hi = 1'b0;
    all_lo = 1'b1;
    for (int i = 0; i < NB; i++) begin
      push[i] = parse_vld && (bank == BW'(i));   // One-hot
      if (level[i] >= wmark_hi) any_hi = 1'b1;
      if (level[i] > wmark_lo) all_lo = 1'b0;
    end
  end

  // aok falls on any high, rises only when all are low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aok <= 1'b1;
    end else if (any_hi) begin
      aok <= 1'b0;
    end else if (all_lo) begin
      aok <= 1'b1;
    end
  end

endmodule

// File: verilog/min_parse.sv
// JBus inbound parser.
// Samples each bus beat, joins a write header with its data beat and checks
// even parity per 16-bit slice. Good requests below the memory size leave as
// a one-cycle parse_vld one clock after the last beat; bad ones are dropped
// and show up as apar or nonex pulses for the CSR block.
`timescale 1ns/1ps
`include "min_defs.svh"

module min_parse (
  input  logic                   clk,
  input  logic                   rst_n,
  input  min_pkg::min_adtype_e   j_adtype,
  input  logic [`MIN_DATA_W-1:0] j_ad,
  input  logic [`MIN_PAR_W-1:0]  j_adp,
  input  logic [7:0]             mem_size,
  output logic                   parse_vld,
  output min_pkg::min_req_t      parse_req,
  output min_pkg::min_err_t      parse_err
);
  import min_pkg::*;

  localparam int SLICE_W = `MIN_DATA_W / `MIN_PAR_W;

  min_parse_state_e       state_q;
  logic [`MIN_ADDR_W-1:0] hdr_addr_q;  // Held write header
  logic                   hdr_perr_q;  // Header had bad parity
  logic                   beat_perr;
  logic                   last_beat;   // Read header or write data
  logic [`MIN_ADDR_W-1:0] cur_addr;
  logic                   cur_perr;
  logic                   cur_nonex;
  logic                   apar_q;
  logic                   nonex_q;
  logic [`MIN_ADDR_W-1:0] err_addr_q;

  // Each adp bit equals the xor of its slice
  always_comb begin
    beat_perr = 1'b0;
    for (int i = 0; i < `MIN_PAR_W; i++) begin
      beat_perr |= j_adp[i] ^ (^j_ad[i*SLICE_W +: SLICE_W]);
    end
  end

  assign last_beat = (state_q == PS_IDLE) ? (j_adtype == AD_RD_HDR) : (j_adtype == AD_WR_DATA);
  assign cur_addr  = (state_q == PS_IDLE) ? j_ad[`MIN_ADDR_W-1:0] : hdr_addr_q;
  assign cur_perr  = beat_perr | ((state_q == PS_WDATA) & hdr_perr_q); // Either beat
  assign cur_nonex = cur_addr[`MIN_ADDR_W-1 -: 8] >= mem_size;

  // ********************
  // Beat FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PS_IDLE;
    end else if (state_q == PS_IDLE) begin
      if (j_adtype == AD_WR_HDR) begin
        state_q <= PS_WDATA;
      end
    end else begin
      state_q <= PS_IDLE;                   // Exactly one data beat
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == PS_IDLE && j_adtype == AD_WR_HDR) begin
      hdr_addr_q <= j_ad[`MIN_ADDR_W-1:0];
      hdr_perr_q <= beat_perr;
    end
  end

  // ********************
  // Outputs, parity wins over range
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      parse_vld <= 1'b0;
      apar_q    <= 1'b0;
      nonex_q   <= 1'b0;
    end else begin
      parse_vld <= last_beat & ~cur_perr & ~cur_nonex;
      apar_q    <= last_beat & cur_perr;
      nonex_q   <= last_beat & ~cur_perr & cur_nonex;
    end
  end

  always_ff @(posedge clk) begin
    if (last_beat) begin
      parse_req.op   <= (state_q == PS_IDLE) ? OP_RD : OP_WR;
      parse_req.addr <= cur_addr;
      parse_req.data <= (state_q == PS_IDLE) ? '0 : j_ad;  // Reads carry no data
      err_addr_q     <= cur_addr;
    end
  end

  assign parse_err = '{apar: apar_q, nonex: nonex_q, addr: err_addr_q};

  // Source never sends data without a header before it
  a_wdata_after_hdr: assert property (@(posedge clk) disable iff (!rst_n)
    (j_adtype == AD_WR_DATA) |-> (state_q == PS_WDATA));

endmodule

// File: verilog/min_pkg.sv
// Types shared by the inbound memory path and its testbench.
// Bus beat and request opcodes, parser state, and the packed structs that
// carry requests, error pulses and APB traffic between blocks.
`include "min_defs.svh"

package min_pkg;

  // ********************
  // Enums
  typedef enum logic [1:0] {
    AD_IDLE    = 2'd0,
    AD_RD_HDR  = 2'd1,  // Read, single beat
    AD_WR_HDR  = 2'd2,  // Write header, data follows
    AD_WR_DATA = 2'd3
  } min_adtype_e;

  typedef enum logic {
    OP_RD = 1'b0,
    OP_WR = 1'b1
  } min_op_e;

  typedef enum logic {
    PS_IDLE  = 1'b0,
    PS_WDATA = 1'b1     // Waiting on write data beat
  } min_parse_state_e;

  // ********************
  // Structs
  typedef struct packed {
    min_op_e                op;
    logic [`MIN_ADDR_W-1:0] addr;
    logic [`MIN_DATA_W-1:0] data;   // Zero for reads
  } min_req_t;

  typedef struct packed {
    logic [$clog2(`MIN_NUM_BANKS)-1:0] bank;
    min_req_t                          req;
  } min_l2_req_t;

  typedef struct packed {
    logic                   apar;   // Address/data parity
    logic                   nonex;  // Beyond memory size
    logic [`MIN_ADDR_W-1:0] addr;   // Header address
  } min_err_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`MIN_APB_AW-1:0] paddr;
    logic [`MIN_APB_DW-1:0] pwdata;
  } min_apb_req_t;

  typedef struct packed {
    logic [`MIN_APB_DW-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } min_apb_rsp_t;

endpackage

// File: include/min_defs.svh
// Sizes, register map and reset values of the JBus memory inbound block.
// Included by the package and by each RTL file that needs a width or offset.
`ifndef MIN_DEFS_SVH
`define MIN_DEFS_SVH

// ********************
// Datapath sizes
`define MIN_NUM_BANKS    4     // L2 banks
`define MIN_RQ_DEPTH     8     // Entries per bank queue
`define MIN_ADDR_W       40    // Request address
`define MIN_DATA_W       64    // Bus word and write data
`define MIN_PAR_W        4     // One even parity bit per 16-bit slice
`define MIN_BANK_LO      6     // Bank select is addr[7:6]

// ********************
// APB register map
`define MIN_APB_AW       8
`define MIN_APB_DW       32
`define MIN_REG_CONFIG   8'h00 // Memory size, compared with addr[39:32]
`define MIN_REG_WMARK    8'h04 // High mark [3:0], low mark [7:4]
`define MIN_REG_ERR      8'h08 // [0] apar, [1] nonex, W1C
`define MIN_REG_LOG      8'h0C // First error address, read only

`define MIN_MEMSIZE_RST  8'h80
`define MIN_WMARK_HI_RST 4'd6
`define MIN_WMARK_LO_RST 4'd2

`endif
